/* verilog/ecc_cfg_pkg.sv */
package ecc_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data path geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // two beats per controller clock
  localparam int n_beats = 2;

  localparam int data_width = 64;
  localparam int ecc_width = 8;
  localparam int code_width = data_width + ecc_width;

  // byte lanes of one beat
  localparam int byte_width = 8;
  localparam int mask_width = data_width / byte_width;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-beat vector types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one beat of payload
  typedef logic [data_width-1:0] beat_data_t;

  // set bit means take that byte from the merge data
  typedef logic [mask_width-1:0] beat_mask_t;

  // check bits, also used for syndromes
  typedef logic [ecc_width-1:0] check_t;

  // data in [63:0], check bit k sits at bit 71-k
  typedef logic [code_width-1:0] code_word_t;

endpackage

/* verilog/ecc_code_pkg.sv */
package ecc_code_pkg;

  import ecc_cfg_pkg::*;

  // one row per check bit, each row spans the whole code word
  typedef code_word_t [ecc_width-1:0] h_matrix_t;

  // number of set bits in a candidate column
  function automatic int unsigned col_weight(input check_t v);
    int unsigned w;
    w = 0;
    for (int i = 0; i < ecc_width; i++) begin
      w += v[i];
    end
    return w;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Hsiao SEC-DED matrix
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Data columns take all 56 weight-3 patterns, then the first
  // eight weight-5 patterns. Every column is odd and distinct, so
  // any double error leaves an even, nonzero syndrome.
  function automatic h_matrix_t build_h_rows();
    h_matrix_t rows;
    check_t col;
    int unsigned n;
    rows = '0;
    n = 0;
    for (int w = 3; w <= 5; w += 2) begin
      for (int v = 0; v < 2 ** ecc_width; v++) begin
        col = check_t'(v);
        if (col_weight(col) == w && n < data_width) begin
          for (int k = 0; k < ecc_width; k++) begin
            rows[k][n] = col[k];
          end
          n++;
        end
      end
    end
    // identity over the check bits
    for (int k = 0; k < ecc_width; k++) begin
      rows[k][code_width-1-k] = 1'b1;
    end
    return rows;
  endfunction

  localparam h_matrix_t h_rows = build_h_rows();

endpackage

/* verilog/ecc_wr_beat_if.sv */
`timescale 1ns/1ps

interface ecc_wr_beat_if;

  import ecc_cfg_pkg::*;

  // one captured write request
  logic valid;
  beat_data_t [n_beats-1:0] data;
  beat_mask_t [n_beats-1:0] mask;
  beat_data_t [n_beats-1:0] merge_data;

  // per-beat raw flag, check bits left at zero
  logic [n_beats-1:0] raw;

  // capture side
  modport src (
    output valid, data, mask, merge_data, raw
  );

  // encoder side
  modport dst (
    input valid, data, mask, merge_data, raw
  );

endinterface

/* verilog/ecc_wr_capture.sv */
`timescale 1ns/1ps

module ecc_wr_capture (
  input  logic clk,
  input  logic reset,
  input  logic wr_valid,
  input  ecc_cfg_pkg::beat_data_t [ecc_cfg_pkg::n_beats-1:0] wr_data,
  input  ecc_cfg_pkg::beat_mask_t [ecc_cfg_pkg::n_beats-1:0] wr_data_mask,
  input  ecc_cfg_pkg::beat_data_t [ecc_cfg_pkg::n_beats-1:0] rd_merge_data,
  input  logic [ecc_cfg_pkg::n_beats-1:0] raw_not_ecc,
  ecc_wr_beat_if.src wr_beat
);

  import ecc_cfg_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input flops
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // strobe only, one per request
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_beat.valid <= 1'b0;
    end else begin
      wr_beat.valid <= wr_valid;
    end
  end

  // payload follows the controller every clock
  always_ff @(posedge clk) begin
    for (int b = 0; b < n_beats; b++) begin
      wr_beat.data[b] <= wr_data[b];
      wr_beat.mask[b] <= wr_data_mask[b];
      wr_beat.merge_data[b] <= rd_merge_data[b];
      wr_beat.raw[b] <= raw_not_ecc[b];
    end
  end

endmodule

/* verilog/ecc_merge_enc.sv */
`timescale 1ns/1ps

module ecc_merge_enc (
  input  logic clk,
  input  logic reset,
  ecc_wr_beat_if.dst wr_beat,
  output ecc_cfg_pkg::code_word_t [ecc_cfg_pkg::n_beats-1:0] mc_wrdata,
  output logic mc_wrdata_valid
);

  import ecc_cfg_pkg::*;
  import ecc_code_pkg::*;

  beat_data_t [n_beats-1:0] merged;
  check_t [n_beats-1:0] check;
  code_word_t [n_beats-1:0] coded;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read-modify-write merge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // masked bytes come from the read-back data
  always_comb begin
    for (int b = 0; b < n_beats; b++) begin
      for (int i = 0; i < mask_width; i++) begin
        if (wr_beat.mask[b][i]) begin
          merged[b][i*byte_width +: byte_width] =
            wr_beat.merge_data[b][i*byte_width +: byte_width];
        end else begin
          merged[b][i*byte_width +: byte_width] =
            wr_beat.data[b][i*byte_width +: byte_width];
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // check bit generation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // parity over the data part of each row
  always_comb begin
    for (int b = 0; b < n_beats; b++) begin
      for (int k = 0; k < ecc_width; k++) begin
        check[b][k] = ^(merged[b] & h_rows[k][data_width-1:0]);
      end
    end
  end

  // check bit k goes to the top, reversed; raw beats carry zeros
  always_comb begin
    for (int b = 0; b < n_beats; b++) begin
      coded[b][data_width-1:0] = merged[b];
      for (int k = 0; k < ecc_width; k++) begin
        coded[b][code_width-1-k] = wr_beat.raw[b] ? 1'b0 : check[b][k];
      end
    end
  end

  // output flops
  always_ff @(posedge clk) begin
    if (reset) begin
      mc_wrdata_valid <= 1'b0;
    end else begin
      mc_wrdata_valid <= wr_beat.valid;
    end
  end

  always_ff @(posedge clk) begin
    mc_wrdata <= coded;
  end

endmodule

/* verilog/ecc_dec_fix.sv */
`timescale 1ns/1ps

module ecc_dec_fix (
  input  logic clk,
  input  logic reset,
  input  logic rd_valid,
  input  ecc_cfg_pkg::code_word_t [ecc_cfg_pkg::n_beats-1:0] rd_code,
  output ecc_cfg_pkg::beat_data_t [ecc_cfg_pkg::n_beats-1:0] rd_data,
  output logic [ecc_cfg_pkg::n_beats-1:0] ecc_single,
  output logic [ecc_cfg_pkg::n_beats-1:0] ecc_multiple,
  output logic rd_data_valid
);

  import ecc_cfg_pkg::*;
  import ecc_code_pkg::*;

  check_t [n_beats-1:0] syndrome;
  beat_data_t [n_beats-1:0] fixed_data;
  logic [n_beats-1:0] data_hit;
  logic [n_beats-1:0] check_hit;
  logic [n_beats-1:0] single_err;
  logic [n_beats-1:0] multi_err;

  // column j of the matrix, in syndrome bit order
  function automatic check_t h_col(input int j);
    check_t col;
    for (int k = 0; k < ecc_width; k++) begin
      col[k] = h_rows[k][j];
    end
    return col;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // syndrome
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int b = 0; b < n_beats; b++) begin
      for (int k = 0; k < ecc_width; k++) begin
        syndrome[b][k] = ^(rd_code[b] & h_rows[k]);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // correction and classification
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int b = 0; b < n_beats; b++) begin
      fixed_data[b] = rd_code[b][data_width-1:0];
      data_hit[b] = 1'b0;
      // flip the data bit whose column matches
      for (int j = 0; j < data_width; j++) begin
        if (syndrome[b] == h_col(j)) begin
          fixed_data[b][j] = ~rd_code[b][j];
          data_hit[b] = 1'b1;
        end
      end
      // a flipped check bit shows up as a one-hot syndrome
      check_hit[b] = $onehot(syndrome[b]);
      single_err[b] = (^syndrome[b]) & (data_hit[b] | check_hit[b]);
      // even weight, or odd with no matching column
      multi_err[b] = (syndrome[b] != '0) &
                     (~(^syndrome[b]) | ~(data_hit[b] | check_hit[b]));
    end
  end

  // output flops
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= fixed_data;
    ecc_single <= single_err;
    ecc_multiple <= multi_err;
  end

endmodule

/* verilog/ecc_datapath_top.sv */
`timescale 1ns/1ps

module ecc_datapath_top (
  input  logic clk,
  input  logic reset,
  // write request from the controller
  input  logic wr_valid,
  input  ecc_cfg_pkg::beat_data_t [ecc_cfg_pkg::n_beats-1:0] wr_data,
  input  ecc_cfg_pkg::beat_mask_t [ecc_cfg_pkg::n_beats-1:0] wr_data_mask,
  input  ecc_cfg_pkg::beat_data_t [ecc_cfg_pkg::n_beats-1:0] rd_merge_data,
  input  logic [ecc_cfg_pkg::n_beats-1:0] raw_not_ecc,
  // coded write data toward the PHY
  output ecc_cfg_pkg::code_word_t [ecc_cfg_pkg::n_beats-1:0] mc_wrdata,
  output logic mc_wrdata_valid,
  // read data from memory
  input  logic rd_valid,
  input  ecc_cfg_pkg::code_word_t [ecc_cfg_pkg::n_beats-1:0] rd_code,
  // corrected read data toward the read port
  output ecc_cfg_pkg::beat_data_t [ecc_cfg_pkg::n_beats-1:0] rd_data,
  output logic [ecc_cfg_pkg::n_beats-1:0] ecc_single,
  output logic [ecc_cfg_pkg::n_beats-1:0] ecc_multiple,
  output logic rd_data_valid
);

  ecc_wr_beat_if wr_beat ();

  ecc_wr_capture u_wr_capture (
    .clk           (clk),
    .reset         (reset),
    .wr_valid      (wr_valid),
    .wr_data       (wr_data),
    .wr_data_mask  (wr_data_mask),
    .rd_merge_data (rd_merge_data),
    .raw_not_ecc   (raw_not_ecc),
    .wr_beat       (wr_beat.src)
  );

  ecc_merge_enc u_merge_enc (
    .clk             (clk),
    .reset           (reset),
    .wr_beat         (wr_beat.dst),
    .mc_wrdata       (mc_wrdata),
    .mc_wrdata_valid (mc_wrdata_valid)
  );

  ecc_dec_fix u_dec_fix (
    .clk           (clk),
    .reset         (reset),
    .rd_valid      (rd_valid),
    .rd_code       (rd_code),
    .rd_data       (rd_data),
    .ecc_single    (ecc_single),
    .ecc_multiple  (ecc_multiple),
    .rd_data_valid (rd_data_valid)
  );

endmodule

/* verif/ecc_datapath_assert.sv */
`timescale 1ns/1ps

module ecc_datapath_assert (
  input logic clk,
  input logic reset,
  input logic wr_valid,
  input logic mc_wrdata_valid,
  input logic rd_valid,
  input logic rd_data_valid,
  input logic [ecc_cfg_pkg::n_beats-1:0] ecc_single,
  input logic [ecc_cfg_pkg::n_beats-1:0] ecc_multiple
);

  // read back by the testbench at the end of the run
  int fail_count = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // strobe timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  wr_latency: assert property (@(posedge clk) disable iff (reset)
    mc_wrdata_valid == $past(wr_valid, 2))
    else begin
      $error("mc_wrdata_valid does not follow wr_valid by two cycles");
      fail_count++;
    end

  rd_latency: assert property (@(posedge clk) disable iff (reset)
    rd_data_valid == $past(rd_valid, 1))
    else begin
      $error("rd_data_valid does not follow rd_valid by one cycle");
      fail_count++;
    end

  // flops clear on the edge that samples reset
  valid_in_reset: assert property (@(posedge clk)
    $past(reset) |-> (!mc_wrdata_valid && !rd_data_valid))
    else begin
      $error("output strobe high during reset");
      fail_count++;
    end

  flags_exclusive: assert property (@(posedge clk) disable iff (reset)
    rd_data_valid |-> ((ecc_single & ecc_multiple) == '0))
    else begin
      $error("single and multiple error flags both set on one beat");
      fail_count++;
    end

endmodule

bind ecc_datapath_top ecc_datapath_assert u_assert (
  .clk             (clk),
  .reset           (reset),
  .wr_valid        (wr_valid),
  .mc_wrdata_valid (mc_wrdata_valid),
  .rd_valid        (rd_valid),
  .rd_data_valid   (rd_data_valid),
  .ecc_single      (ecc_single),
  .ecc_multiple    (ecc_multiple)
);

/* verif/ecc_datapath_tb.sv */
`timescale 1ns/1ps

module ecc_datapath_tb;

  import ecc_cfg_pkg::*;
  import ecc_code_pkg::*;

  localparam int drain_timeout = 50;

  typedef code_word_t [n_beats-1:0] wr_word_t;
  typedef struct packed {
    beat_data_t [n_beats-1:0] data;
    logic [n_beats-1:0] single;
    logic [n_beats-1:0] multi;
    logic check_data;
  } rd_exp_t;

  logic clk;
  logic reset;
  logic wr_valid;
  beat_data_t [n_beats-1:0] wr_data;
  beat_mask_t [n_beats-1:0] wr_data_mask;
  beat_data_t [n_beats-1:0] rd_merge_data;
  logic [n_beats-1:0] raw_not_ecc;
  code_word_t [n_beats-1:0] mc_wrdata;
  logic mc_wrdata_valid;
  logic rd_valid;
  code_word_t [n_beats-1:0] rd_code;
  beat_data_t [n_beats-1:0] rd_data;
  logic [n_beats-1:0] ecc_single;
  logic [n_beats-1:0] ecc_multiple;
  logic rd_data_valid;

  logic [31:0] lfsr_state = 32'h886c;
  wr_word_t exp_wr_q[$];
  rd_exp_t exp_rd_q[$];
  code_word_t clean_pool[$];
  wr_word_t wr_cur;
  rd_exp_t rd_cur;
  string cur_test;
  int test_errors;
  int test_checks;
  int tests_passed = 0;
  int tests_failed = 0;
  int assert_fails;

  ecc_datapath_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random source and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic beat_data_t merge_bytes(input beat_data_t d, input beat_mask_t m,
                                             input beat_data_t rb);
    beat_data_t r;
    for (int j = 0; j < data_width; j++) begin
      r[j] = m[j / byte_width] ? rb[j] : d[j];
    end
    return r;
  endfunction

  // toggle check bit k for every set data bit in row k
  function automatic code_word_t encode_beat(input beat_data_t d, input logic raw);
    check_t c;
    code_word_t cw;
    c = '0;
    for (int j = 0; j < data_width; j++) begin
      for (int k = 0; k < ecc_width; k++) begin
        if (d[j] && h_rows[k][j]) begin
          c[k] = ~c[k];
        end
      end
    end
    cw[data_width-1:0] = d;
    for (int k = 0; k < ecc_width; k++) begin
      cw[code_width-1-k] = raw ? 1'b0 : c[k];
    end
    return cw;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output monitors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    if (!reset && mc_wrdata_valid) begin
      if (exp_wr_q.size() == 0) begin
        $display("%s: write strobe arrived with no request pending", cur_test);
        test_errors++;
      end else begin
        wr_cur = exp_wr_q.pop_front();
        for (int b = 0; b < n_beats; b++) begin
          test_checks += 2;
          assert (mc_wrdata[b][data_width-1:0] == wr_cur[b][data_width-1:0]) else begin
            $display("Error: %s beat %0d data expected %h actual %h", cur_test, b,
                     wr_cur[b][data_width-1:0], mc_wrdata[b][data_width-1:0]);
            test_errors++;
          end
          assert (mc_wrdata[b][code_width-1:data_width] ==
                  wr_cur[b][code_width-1:data_width]) else begin
            $display("Error: %s beat %0d check expected %h actual %h", cur_test, b,
                     wr_cur[b][code_width-1:data_width],
                     mc_wrdata[b][code_width-1:data_width]);
            test_errors++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && rd_data_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("%s: read strobe arrived with no read pending", cur_test);
        test_errors++;
      end else begin
        rd_cur = exp_rd_q.pop_front();
        test_checks += 2;
        assert (ecc_single == rd_cur.single) else begin
          $display("Error: %s ecc_single expected %b actual %b", cur_test,
                   rd_cur.single, ecc_single);
          test_errors++;
        end
        assert (ecc_multiple == rd_cur.multi) else begin
          $display("Error: %s ecc_multiple expected %b actual %b", cur_test,
                   rd_cur.multi, ecc_multiple);
          test_errors++;
        end
        if (rd_cur.check_data) begin
          test_checks++;
          assert (rd_data == rd_cur.data) else begin
            $display("Error: %s rd_data expected %h actual %h", cur_test,
                     rd_cur.data, rd_data);
            test_errors++;
          end
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %-8s %s, %0d checks, %0d errors", cur_test,
             (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
  endtask

  // raw_mode set puts one beat of each request in raw mode, alternating
  task automatic drive_writes(input int n, input logic rand_mask, input logic raw_mode);
    beat_data_t [n_beats-1:0] d;
    beat_mask_t [n_beats-1:0] m;
    beat_data_t [n_beats-1:0] rb;
    logic [n_beats-1:0] raw;
    wr_word_t e;
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < n_beats; b++) begin
        d[b] = take_bits(data_width);
        rb[b] = take_bits(data_width);
        m[b] = rand_mask ? beat_mask_t'(take_bits(mask_width)) : '0;
        raw[b] = raw_mode && ((i % n_beats) == b);
        e[b] = encode_beat(merge_bytes(d[b], m[b], rb[b]), raw[b]);
        if (!raw[b]) begin
          clean_pool.push_back(e[b]);
        end
      end
      @(posedge clk);
      wr_valid <= 1'b1;
      wr_data <= d;
      wr_data_mask <= m;
      rd_merge_data <= rb;
      raw_not_ecc <= raw;
      exp_wr_q.push_back(e);
    end
    @(posedge clk);
    wr_valid <= 1'b0;
  endtask

  // flips holds 0, 1 or 2 distinct bit errors per beat
  task automatic drive_reads(input int n, input int flips);
    code_word_t [n_beats-1:0] codes;
    rd_exp_t e;
    logic [63:0] r;
    int p1;
    int p2;
    for (int i = 0; i < n; i++) begin
      e.check_data = (flips < 2);
      for (int b = 0; b < n_beats; b++) begin
        codes[b] = clean_pool[(i * n_beats + b) % clean_pool.size()];
        e.data[b] = codes[b][data_width-1:0];
        r = take_bits(13);
        p1 = int'(r[6:0]) % code_width;
        p2 = (p1 + 1 + int'(r[12:7]) % (code_width - 1)) % code_width;
        if (flips >= 1) begin
          codes[b][p1] = ~codes[b][p1];
        end
        if (flips == 2) begin
          codes[b][p2] = ~codes[b][p2];
        end
        e.single[b] = (flips == 1);
        e.multi[b] = (flips == 2);
      end
      @(posedge clk);
      rd_valid <= 1'b1;
      rd_code <= codes;
      exp_rd_q.push_back(e);
    end
    @(posedge clk);
    rd_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    for (int t = 0; t < drain_timeout; t++) begin
      if (exp_wr_q.size() == 0 && exp_rd_q.size() == 0) begin
        break;
      end
      @(posedge clk);
    end
    if (exp_wr_q.size() != 0 || exp_rd_q.size() != 0) begin
      $display("%s: timed out, %0d write and %0d read results never arrived",
               cur_test, exp_wr_q.size(), exp_rd_q.size());
      test_errors++;
      exp_wr_q.delete();
      exp_rd_q.delete();
    end
  endtask

  initial begin
    reset = 1'b1;
    wr_valid = 1'b0;
    wr_data = '0;
    wr_data_mask = '0;
    rd_merge_data = '0;
    raw_not_ecc = '0;
    rd_valid = 1'b0;
    rd_code = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    start_test("merge");
    drive_writes(16, 1'b1, 1'b0);
    wait_drain();
    end_test();

    start_test("encode");
    drive_writes(16, 1'b0, 1'b0);
    wait_drain();
    end_test();

    start_test("raw");
    drive_writes(8, 1'b1, 1'b1);
    wait_drain();
    end_test();

    start_test("clean");
    drive_reads(12, 0);
    wait_drain();
    end_test();

    start_test("single");
    drive_reads(24, 1);
    wait_drain();
    end_test();

    start_test("double");
    drive_reads(24, 2);
    wait_drain();
    end_test();

    repeat (4) @(posedge clk);
    assert_fails = u_dut.u_assert.fail_count;
    if (assert_fails != 0) begin
      $display("timing assertions failed %0d times", assert_fails);
    end
    $display("tests passed %0d, failed %0d, assertion failures %0d",
             tests_passed, tests_failed, assert_fails);
    if (tests_failed == 0 && assert_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
verilog/ecc_cfg_pkg.sv
verilog/ecc_code_pkg.sv
verilog/ecc_wr_beat_if.sv
verilog/ecc_wr_capture.sv
verilog/ecc_merge_enc.sv
verilog/ecc_dec_fix.sv
verilog/ecc_datapath_top.sv
verif/ecc_datapath_assert.sv
verif/ecc_datapath_tb.sv

/* Makefile */
# Verilator build and run of the ECC data path testbench

VERILATOR ?= verilator
TOP       ?= ecc_datapath_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
